/* src/rrag_macros.svh */
`ifndef RRAG_MACROS_SVH
`define RRAG_MACROS_SVH

// general register width.
`define RRAG_DATA_W 32

// segment selector width.
`define RRAG_SEG_W 16

// instance tag, wraps at 128.
`define RRAG_TAG_W 7

`define RRAG_NUM_REGS 8 // per file, gpr and segment alike.

`define RRAG_IDX_W 3

`endif

/* src/rrag_data_pkg.sv */
`include "rrag_macros.svh"

package rrag_data_pkg;

    // full dword register value.
    typedef logic [`RRAG_DATA_W-1:0] data_t;

    typedef logic [`RRAG_DATA_W-1:0] addr_t; // linear address.

    // segment selector, shifted left 16 to form the segment base.
    typedef logic [`RRAG_SEG_W-1:0] seg_t;

    typedef logic [`RRAG_TAG_W-1:0] tag_t; // owner of a pending mark.

endpackage

/* src/rrag_uop_pkg.sv */
`include "rrag_macros.svh"

package rrag_uop_pkg;

    // index into either register file.
    typedef logic [`RRAG_IDX_W-1:0] reg_idx_t;

    // 0 byte, 1 word, 2 dword, 3 read as dword.
    typedef logic [1:0] opsize_t;

    typedef logic [1:0] scale_t; // index shift amount.

    // any nonzero value means the memory operand is used.
    typedef logic [1:0] mem_rw_t;

    // one bit per register written by the micro-op.
    typedef logic [`RRAG_NUM_REGS-1:0] reg_mask_t;

endpackage

/* src/rrag_ctrl.sv */
`timescale 1ns/100ps

module rrag_ctrl (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   valid_in,
    input  logic                   latch_empty,
    input  logic                   fwd_stall,
    input  rrag_uop_pkg::mem_rw_t  mem1_rw,
    input  rrag_uop_pkg::mem_rw_t  mem2_rw,
    input  logic                   usereg2,
    input  logic                   usereg3,
    input  logic                   pend_r2,
    input  logic                   pend_r3,
    input  logic                   pend_r4,
    input  logic                   pend_s1,
    input  logic                   pend_s2,
    output logic                   valid_out,
    output logic                   stall,
    output rrag_data_pkg::tag_t    inst_tag
);

    logic mem1_use;
    logic mem2_use;
    logic mem1_stall;
    logic mem2_stall;

    assign mem1_use = |mem1_rw;
    assign mem2_use = |mem2_rw;

    // base/index registers only matter when the micro-op names them.
    assign mem1_stall = mem1_use && ((usereg2 && pend_r2) || (usereg3 && pend_r3) || pend_s1);
    assign mem2_stall = mem2_use && (pend_r4 || pend_s2);

    assign stall     = fwd_stall || mem1_stall || mem2_stall;
    assign valid_out = valid_in && !latch_empty && !stall;

    always_ff @(posedge clk) begin
        if (reset) begin
            inst_tag <= '0;
        end else if (valid_out) begin
            inst_tag <= inst_tag + rrag_data_pkg::tag_t'(1); // wraps at 128.
        end
    end

endmodule

/* src/gpr_file.sv */
`timescale 1ns/100ps
`include "rrag_macros.svh"

module gpr_file (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     ptc_clear,
    input  rrag_uop_pkg::reg_idx_t   rd_addr1,
    input  rrag_uop_pkg::reg_idx_t   rd_addr2,
    input  rrag_uop_pkg::reg_idx_t   rd_addr3,
    input  rrag_uop_pkg::reg_idx_t   rd_addr4,
    input  rrag_uop_pkg::opsize_t    rd_size,
    output rrag_data_pkg::data_t     rd_data1,
    output rrag_data_pkg::data_t     rd_data2,
    output rrag_data_pkg::data_t     rd_data3,
    output rrag_data_pkg::data_t     rd_data4,
    output rrag_data_pkg::data_t     rd_full2,
    output rrag_data_pkg::data_t     rd_full3,
    output rrag_data_pkg::data_t     rd_full4,
    output logic                     pend2,
    output logic                     pend3,
    output logic                     pend4,
    input  logic                     alloc,
    input  rrag_uop_pkg::reg_mask_t  alloc_mask,
    input  rrag_data_pkg::tag_t      alloc_tag,
    input  logic                     wb_ld1,
    input  logic                     wb_ld2,
    input  rrag_uop_pkg::reg_idx_t   wb_addr1,
    input  rrag_uop_pkg::reg_idx_t   wb_addr2,
    input  rrag_data_pkg::data_t     wb_data1,
    input  rrag_data_pkg::data_t     wb_data2,
    input  rrag_uop_pkg::opsize_t    wb_size,
    input  rrag_data_pkg::tag_t      wb_tag
);

    rrag_data_pkg::data_t      regs [`RRAG_NUM_REGS];
    rrag_data_pkg::tag_t       owner [`RRAG_NUM_REGS];
    logic [`RRAG_NUM_REGS-1:0] pending;
    logic [`RRAG_NUM_REGS-1:0] wb_hit;

    // low byte or word, zero extended.
    function automatic rrag_data_pkg::data_t sized_read(input rrag_data_pkg::data_t value,
                                                       input rrag_uop_pkg::opsize_t size);
        case (size)
            2'd0:    sized_read = rrag_data_pkg::data_t'(value[7:0]);
            2'd1:    sized_read = rrag_data_pkg::data_t'(value[15:0]);
            default: sized_read = value;
        endcase
    endfunction

    function automatic rrag_data_pkg::data_t sized_merge(input rrag_data_pkg::data_t old_value,
                                                        input rrag_data_pkg::data_t new_value,
                                                        input rrag_uop_pkg::opsize_t size);
        case (size)
            2'd0:    sized_merge = {old_value[`RRAG_DATA_W-1:8], new_value[7:0]};
            2'd1:    sized_merge = {old_value[`RRAG_DATA_W-1:16], new_value[15:0]};
            default: sized_merge = new_value;
        endcase
    endfunction

    always_comb begin
        for (int i = 0; i < `RRAG_NUM_REGS; i++) begin
            wb_hit[i] = (wb_ld1 && wb_addr1 == rrag_uop_pkg::reg_idx_t'(i)) ||
                        (wb_ld2 && wb_addr2 == rrag_uop_pkg::reg_idx_t'(i));
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RRAG_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wb_ld1) begin
                regs[wb_addr1] <= sized_merge(regs[wb_addr1], wb_data1, wb_size);
            end
            if (wb_ld2) begin // port 2 lands last on a shared address.
                regs[wb_addr2] <= sized_merge(regs[wb_addr2], wb_data2, wb_size);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
        end else begin
            for (int i = 0; i < `RRAG_NUM_REGS; i++) begin
                if (alloc && alloc_mask[i]) begin
                    pending[i] <= 1'b1; // new owner beats a clear on the same edge.
                end else if (ptc_clear || (wb_hit[i] && owner[i] == wb_tag)) begin
                    pending[i] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `RRAG_NUM_REGS; i++) begin
            if (alloc && alloc_mask[i]) begin
                owner[i] <= alloc_tag;
            end
        end
    end

    assign rd_data1 = sized_read(regs[rd_addr1], rd_size);
    assign rd_data2 = sized_read(regs[rd_addr2], rd_size);
    assign rd_data3 = sized_read(regs[rd_addr3], rd_size);
    assign rd_data4 = sized_read(regs[rd_addr4], rd_size);

    // address path wants the whole register.
    assign rd_full2 = regs[rd_addr2];
    assign rd_full3 = regs[rd_addr3];
    assign rd_full4 = regs[rd_addr4];

    assign pend2 = pending[rd_addr2];
    assign pend3 = pending[rd_addr3];
    assign pend4 = pending[rd_addr4];

endmodule

/* src/seg_file.sv */
`timescale 1ns/100ps
`include "rrag_macros.svh"

module seg_file (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     ptc_clear,
    input  rrag_uop_pkg::reg_idx_t   rd_addr1,
    input  rrag_uop_pkg::reg_idx_t   rd_addr2,
    output rrag_data_pkg::seg_t      rd_sel1,
    output rrag_data_pkg::seg_t      rd_sel2,
    output logic                     pend1,
    output logic                     pend2,
    input  logic                     alloc,
    input  rrag_uop_pkg::reg_mask_t  alloc_mask,
    input  rrag_data_pkg::tag_t      alloc_tag,
    input  logic                     wb_ld,
    input  rrag_uop_pkg::reg_idx_t   wb_addr,
    input  rrag_data_pkg::seg_t      wb_sel,
    input  rrag_data_pkg::tag_t      wb_tag
);

    rrag_data_pkg::seg_t       sels [`RRAG_NUM_REGS];
    rrag_data_pkg::tag_t       owner [`RRAG_NUM_REGS];
    logic [`RRAG_NUM_REGS-1:0] pending;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RRAG_NUM_REGS; i++) begin
                sels[i] <= '0;
            end
        end else if (wb_ld) begin
            sels[wb_addr] <= wb_sel;
        end
    end

    // same scoreboard rules as the gpr side.
    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
        end else begin
            for (int i = 0; i < `RRAG_NUM_REGS; i++) begin
                if (alloc && alloc_mask[i]) begin
                    pending[i] <= 1'b1;
                end else if (ptc_clear ||
                             (wb_ld && wb_addr == rrag_uop_pkg::reg_idx_t'(i) &&
                              owner[i] == wb_tag)) begin
                    pending[i] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `RRAG_NUM_REGS; i++) begin
            if (alloc && alloc_mask[i]) begin
                owner[i] <= alloc_tag;
            end
        end
    end

    assign rd_sel1 = sels[rd_addr1];
    assign rd_sel2 = sels[rd_addr2];
    assign pend1   = pending[rd_addr1];
    assign pend2   = pending[rd_addr2];

endmodule

/* src/agu.sv */
`timescale 1ns/100ps

module agu (
    input  rrag_data_pkg::data_t    base,
    input  rrag_data_pkg::data_t    index,
    input  rrag_data_pkg::data_t    second,
    input  rrag_data_pkg::seg_t     seg1,
    input  rrag_data_pkg::seg_t     seg2,
    input  rrag_data_pkg::addr_t    disp,
    input  rrag_uop_pkg::scale_t    scale,
    input  logic                    usereg2,
    input  logic                    usereg3,
    input  logic                    addressingmode, // 1 for 32-bit addressing.
    input  logic                    is_rep,
    input  rrag_uop_pkg::opsize_t   opsize,
    output rrag_data_pkg::addr_t    mem_addr1,
    output rrag_data_pkg::addr_t    mem_addr2,
    output rrag_data_pkg::addr_t    mem_addr1_end,
    output rrag_data_pkg::addr_t    mem_addr2_end,
    output rrag_data_pkg::addr_t    rep_num
);

    rrag_data_pkg::addr_t base_a;
    rrag_data_pkg::addr_t index_a;
    rrag_data_pkg::addr_t second_a;
    rrag_data_pkg::addr_t offset;
    rrag_data_pkg::addr_t size_m1;

    // 16-bit mode only sees the low word of each register.
    assign base_a   = addressingmode ? base   : rrag_data_pkg::addr_t'(base[15:0]);
    assign index_a  = addressingmode ? index  : rrag_data_pkg::addr_t'(index[15:0]);
    assign second_a = addressingmode ? second : rrag_data_pkg::addr_t'(second[15:0]);

    always_comb begin
        if (usereg3) begin
            offset = (usereg2 ? base_a : '0) + (index_a << scale);
        end else begin
            offset = base_a;
        end
    end

    assign mem_addr1 = offset + disp + {seg1, 16'h0000};
    assign mem_addr2 = second_a + {seg2, 16'h0000};

    always_comb begin
        case (opsize)
            2'd0:    size_m1 = 32'd0;
            2'd1:    size_m1 = 32'd1;
            default: size_m1 = 32'd3; // dword, also for size 3.
        endcase
    end

    assign mem_addr1_end = mem_addr1 + size_m1;
    assign mem_addr2_end = mem_addr2 + size_m1;

    assign rep_num = is_rep ? second : '0; // count register, unsized.

endmodule

/* src/rrag_top.sv */
`timescale 1ns/100ps

module rrag_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     valid_in,
    input  logic                     latch_empty,
    input  logic                     fwd_stall,
    input  logic                     ptc_clear,
    input  rrag_uop_pkg::reg_idx_t   reg_addr1,
    input  rrag_uop_pkg::reg_idx_t   reg_addr2,
    input  rrag_uop_pkg::reg_idx_t   reg_addr3,
    input  rrag_uop_pkg::reg_idx_t   reg_addr4,
    input  rrag_uop_pkg::reg_idx_t   seg_addr1,
    input  rrag_uop_pkg::reg_idx_t   seg_addr2,
    input  rrag_uop_pkg::opsize_t    opsize,
    input  logic                     addressingmode,
    input  logic                     usereg2,
    input  logic                     usereg3,
    input  rrag_uop_pkg::scale_t     reg3_scale,
    input  rrag_data_pkg::addr_t     disp,
    input  rrag_uop_pkg::mem_rw_t    mem1_rw,
    input  rrag_uop_pkg::mem_rw_t    mem2_rw,
    input  logic                     is_rep,
    input  rrag_uop_pkg::reg_mask_t  dest_gpr,
    input  rrag_uop_pkg::reg_mask_t  dest_seg,
    input  logic                     wb_ld1,
    input  logic                     wb_ld2,
    input  rrag_uop_pkg::reg_idx_t   wb_addr1,
    input  rrag_uop_pkg::reg_idx_t   wb_addr2,
    input  rrag_data_pkg::data_t     wb_data1,
    input  rrag_data_pkg::data_t     wb_data2,
    input  rrag_uop_pkg::opsize_t    wb_opsize,
    input  rrag_data_pkg::tag_t      wb_tag,
    input  logic                     wb_seg_ld,
    input  rrag_uop_pkg::reg_idx_t   wb_seg_addr,
    input  rrag_data_pkg::seg_t      wb_seg_data,
    output logic                     valid_out,
    output logic                     stall,
    output rrag_data_pkg::tag_t      inst_tag,
    output rrag_data_pkg::data_t     reg1,
    output rrag_data_pkg::data_t     reg2,
    output rrag_data_pkg::data_t     reg3,
    output rrag_data_pkg::data_t     reg4,
    output rrag_data_pkg::seg_t      seg1,
    output rrag_data_pkg::seg_t      seg2,
    output rrag_data_pkg::addr_t     mem_addr1,
    output rrag_data_pkg::addr_t     mem_addr2,
    output rrag_data_pkg::addr_t     mem_addr1_end,
    output rrag_data_pkg::addr_t     mem_addr2_end,
    output rrag_data_pkg::addr_t     rep_num
);

    rrag_data_pkg::data_t full2;
    rrag_data_pkg::data_t full3;
    rrag_data_pkg::data_t full4;
    logic pend_r2;
    logic pend_r3;
    logic pend_r4;
    logic pend_s1;
    logic pend_s2;

    rrag_ctrl ctrl_i (
        .clk(clk), .reset(reset), .valid_in(valid_in), .latch_empty(latch_empty),
        .fwd_stall(fwd_stall), .mem1_rw(mem1_rw), .mem2_rw(mem2_rw),
        .usereg2(usereg2), .usereg3(usereg3), .pend_r2(pend_r2), .pend_r3(pend_r3),
        .pend_r4(pend_r4), .pend_s1(pend_s1), .pend_s2(pend_s2),
        .valid_out(valid_out), .stall(stall), .inst_tag(inst_tag)
    );

    // an advancing micro-op claims its destinations in both files.
    gpr_file gpr_i (
        .clk(clk), .reset(reset), .ptc_clear(ptc_clear),
        .rd_addr1(reg_addr1), .rd_addr2(reg_addr2), .rd_addr3(reg_addr3),
        .rd_addr4(reg_addr4), .rd_size(opsize),
        .rd_data1(reg1), .rd_data2(reg2), .rd_data3(reg3), .rd_data4(reg4),
        .rd_full2(full2), .rd_full3(full3), .rd_full4(full4),
        .pend2(pend_r2), .pend3(pend_r3), .pend4(pend_r4),
        .alloc(valid_out), .alloc_mask(dest_gpr), .alloc_tag(inst_tag),
        .wb_ld1(wb_ld1), .wb_ld2(wb_ld2), .wb_addr1(wb_addr1), .wb_addr2(wb_addr2),
        .wb_data1(wb_data1), .wb_data2(wb_data2), .wb_size(wb_opsize), .wb_tag(wb_tag)
    );

    seg_file seg_i (
        .clk(clk), .reset(reset), .ptc_clear(ptc_clear),
        .rd_addr1(seg_addr1), .rd_addr2(seg_addr2), .rd_sel1(seg1), .rd_sel2(seg2),
        .pend1(pend_s1), .pend2(pend_s2),
        .alloc(valid_out), .alloc_mask(dest_seg), .alloc_tag(inst_tag),
        .wb_ld(wb_seg_ld), .wb_addr(wb_seg_addr), .wb_sel(wb_seg_data), .wb_tag(wb_tag)
    );

    agu agu_i (
        .base(full2), .index(full3), .second(full4), .seg1(seg1), .seg2(seg2),
        .disp(disp), .scale(reg3_scale), .usereg2(usereg2), .usereg3(usereg3),
        .addressingmode(addressingmode), .is_rep(is_rep), .opsize(opsize),
        .mem_addr1(mem_addr1), .mem_addr2(mem_addr2), .mem_addr1_end(mem_addr1_end),
        .mem_addr2_end(mem_addr2_end), .rep_num(rep_num)
    );

endmodule

/* verif/rrag_properties.sv */
`timescale 1ns/100ps

module rrag_properties (
    input logic                clk,
    input logic                reset,
    input logic                valid_out,
    input logic                stall,
    input rrag_data_pkg::tag_t inst_tag
);

    // a stalled micro-op never advances.
    assert property (@(posedge clk) !(stall && valid_out))
        else $error("stall and valid_out both high");

    assert property (@(posedge clk) reset |-> !valid_out)
        else $error("valid_out high during reset");

    assert property (@(posedge clk) disable iff (reset)
        valid_out |=> inst_tag == rrag_data_pkg::tag_t'($past(inst_tag) + 7'd1))
        else $error("inst_tag did not advance by one");

    assert property (@(posedge clk) disable iff (reset)
        !valid_out |=> $stable(inst_tag))
        else $error("inst_tag moved without valid_out");

endmodule

bind rrag_top rrag_properties props_i (
    .clk(clk), .reset(reset), .valid_out(valid_out), .stall(stall), .inst_tag(inst_tag)
);

/* verif/rrag_tb.sv */
`timescale 1ns/100ps
`include "rrag_macros.svh"

module rrag_tb;

    logic clk = 1'b0;
    logic reset, valid_in, latch_empty, fwd_stall, ptc_clear;
    rrag_uop_pkg::reg_idx_t reg_addr1, reg_addr2, reg_addr3, reg_addr4, seg_addr1, seg_addr2;
    rrag_uop_pkg::opsize_t opsize, wb_opsize;
    logic addressingmode, usereg2, usereg3, is_rep, wb_ld1, wb_ld2, wb_seg_ld;
    rrag_uop_pkg::scale_t reg3_scale;
    rrag_data_pkg::addr_t disp;
    rrag_uop_pkg::mem_rw_t mem1_rw, mem2_rw;
    rrag_uop_pkg::reg_mask_t dest_gpr, dest_seg;
    rrag_uop_pkg::reg_idx_t wb_addr1, wb_addr2, wb_seg_addr;
    rrag_data_pkg::data_t wb_data1, wb_data2;
    rrag_data_pkg::tag_t wb_tag;
    rrag_data_pkg::seg_t wb_seg_data;
    logic valid_out, stall;
    rrag_data_pkg::tag_t inst_tag;
    rrag_data_pkg::data_t reg1, reg2, reg3, reg4;
    rrag_data_pkg::seg_t seg1, seg2;
    rrag_data_pkg::addr_t mem_addr1, mem_addr2, mem_addr1_end, mem_addr2_end, rep_num;

    // reference model state.
    rrag_data_pkg::data_t m_gpr [`RRAG_NUM_REGS];
    rrag_data_pkg::tag_t  m_gtag [`RRAG_NUM_REGS];
    logic                 m_gpend [`RRAG_NUM_REGS];
    rrag_data_pkg::seg_t  m_seg [`RRAG_NUM_REGS];
    rrag_data_pkg::tag_t  m_stag [`RRAG_NUM_REGS];
    logic                 m_spend [`RRAG_NUM_REGS];
    rrag_data_pkg::tag_t  m_tag;
    logic exp_valid, last_stall;
    integer seed = 32'h62b8_4693;
    int mismatches = 0;
    int failures = 0;
    rrag_data_pkg::tag_t owner_tag;

    rrag_top rrag_top_i (.*);

    always #50 clk = ~clk;

    initial begin
        #(100 * 50000);
        $display("watchdog expired, simulation did not finish");
        $display("SIMULATION FAILED");
        $finish;
    end

    task automatic check_data(input string name, input rrag_data_pkg::data_t exp,
                              input rrag_data_pkg::data_t act);
        if (exp !== act) begin
            mismatches++;
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input rrag_data_pkg::addr_t exp,
                              input rrag_data_pkg::addr_t act);
        if (exp !== act) begin
            mismatches++;
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_seg(input string name, input rrag_data_pkg::seg_t exp,
                             input rrag_data_pkg::seg_t act);
        if (exp !== act) begin
            mismatches++;
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_tag(input string name, input rrag_data_pkg::tag_t exp,
                             input rrag_data_pkg::tag_t act);
        if (exp !== act) begin
            mismatches++;
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            mismatches++;
            $display("MISMATCH %s expected %b actual %b", name, exp, act);
        end
    endtask

    function automatic rrag_data_pkg::data_t low_part(input rrag_data_pkg::data_t v,
                                                     input rrag_uop_pkg::opsize_t s);
        if (s == 2'd0) return {24'h0, v[7:0]};
        if (s == 2'd1) return {16'h0, v[15:0]};
        return v;
    endfunction

    function automatic rrag_data_pkg::data_t addr_view(input rrag_data_pkg::data_t v);
        return addressingmode ? v : {16'h0, v[15:0]}; // 16-bit mode truncation.
    endfunction

    task automatic check_outputs(input string name);
        rrag_data_pkg::addr_t off, a1, a2, size_m1;
        logic es;
        es = fwd_stall ||
             (|mem1_rw && ((usereg2 && m_gpend[reg_addr2]) || (usereg3 && m_gpend[reg_addr3]) ||
                           m_spend[seg_addr1])) ||
             (|mem2_rw && (m_gpend[reg_addr4] || m_spend[seg_addr2]));
        exp_valid = valid_in && !latch_empty && !es;
        if (usereg3)
            off = (usereg2 ? addr_view(m_gpr[reg_addr2]) : 32'd0) +
                  (addr_view(m_gpr[reg_addr3]) << reg3_scale);
        else
            off = addr_view(m_gpr[reg_addr2]);
        a1 = off + disp + {m_seg[seg_addr1], 16'h0};
        a2 = addr_view(m_gpr[reg_addr4]) + {m_seg[seg_addr2], 16'h0};
        size_m1 = (opsize == 2'd0) ? 32'd0 : (opsize == 2'd1) ? 32'd1 : 32'd3;
        check_bit({name, " stall"}, es, stall);
        check_bit({name, " valid_out"}, exp_valid, valid_out);
        check_tag({name, " inst_tag"}, m_tag, inst_tag);
        check_data({name, " reg1"}, low_part(m_gpr[reg_addr1], opsize), reg1);
        check_data({name, " reg2"}, low_part(m_gpr[reg_addr2], opsize), reg2);
        check_data({name, " reg3"}, low_part(m_gpr[reg_addr3], opsize), reg3);
        check_data({name, " reg4"}, low_part(m_gpr[reg_addr4], opsize), reg4);
        check_seg({name, " seg1"}, m_seg[seg_addr1], seg1);
        check_seg({name, " seg2"}, m_seg[seg_addr2], seg2);
        check_addr({name, " mem_addr1"}, a1, mem_addr1);
        check_addr({name, " mem_addr2"}, a2, mem_addr2);
        check_addr({name, " mem_addr1_end"}, a1 + size_m1, mem_addr1_end);
        check_addr({name, " mem_addr2_end"}, a2 + size_m1, mem_addr2_end);
        check_addr({name, " rep_num"}, is_rep ? m_gpr[reg_addr4] : 32'd0, rep_num);
    endtask

    task automatic update_model();
        rrag_data_pkg::data_t old_gpr [`RRAG_NUM_REGS];
        logic hit;
        old_gpr = m_gpr;
        // both ports merge into the old value; port 2 lands last.
        if (wb_ld1) m_gpr[wb_addr1] = {old_gpr[wb_addr1] & ~low_part('1, wb_opsize)} |
                                      low_part(wb_data1, wb_opsize);
        if (wb_ld2) m_gpr[wb_addr2] = {old_gpr[wb_addr2] & ~low_part('1, wb_opsize)} |
                                      low_part(wb_data2, wb_opsize);
        if (wb_seg_ld) m_seg[wb_seg_addr] = wb_seg_data;
        for (int k = 0; k < `RRAG_NUM_REGS; k++) begin
            hit = (wb_ld1 && wb_addr1 == 3'(k)) || (wb_ld2 && wb_addr2 == 3'(k));
            if (exp_valid && dest_gpr[k]) begin
                m_gpend[k] = 1'b1;
                m_gtag[k] = m_tag;
            end else if (ptc_clear || (hit && m_gtag[k] == wb_tag)) begin
                m_gpend[k] = 1'b0;
            end
            hit = wb_seg_ld && wb_seg_addr == 3'(k);
            if (exp_valid && dest_seg[k]) begin
                m_spend[k] = 1'b1;
                m_stag[k] = m_tag;
            end else if (ptc_clear || (hit && m_stag[k] == wb_tag)) begin
                m_spend[k] = 1'b0;
            end
        end
        if (exp_valid) m_tag = m_tag + 7'd1;
    endtask

    task automatic cycle(input string name);
        @(negedge clk);
        last_stall = stall;
        check_outputs(name);
        update_model();
        @(posedge clk);
    endtask

    task automatic wait_stall_low(input string name, input int limit);
        int n;
        n = 0;
        cycle(name);
        while (last_stall && n < limit) begin
            cycle(name);
            n++;
        end
        if (last_stall) begin
            failures++;
            $display("timeout in %s: stall still high after %0d cycles", name, limit);
        end
    endtask

    task automatic drive_idle();
        {valid_in, latch_empty, fwd_stall, ptc_clear, is_rep} <= '0;
        {reg_addr1, reg_addr2, reg_addr3, reg_addr4, seg_addr1, seg_addr2} <= '0;
        {opsize, reg3_scale, mem1_rw, mem2_rw, usereg2, usereg3} <= '0;
        addressingmode <= 1'b1;
        disp <= '0;
        {dest_gpr, dest_seg, wb_ld1, wb_ld2, wb_seg_ld} <= '0;
        {wb_addr1, wb_addr2, wb_seg_addr, wb_opsize, wb_tag} <= '0;
        {wb_data1, wb_data2, wb_seg_data} <= '0;
    endtask

    task automatic drive_random();
        rrag_uop_pkg::reg_idx_t a;
        a = 3'($random(seed));
        valid_in <= 1'($random(seed));
        latch_empty <= (($random(seed) & 3) == 0);
        fwd_stall <= (($random(seed) & 7) == 0);
        ptc_clear <= (($random(seed) & 31) == 0);
        {reg_addr1, reg_addr2, reg_addr3, reg_addr4} <= 12'($random(seed));
        {seg_addr1, seg_addr2, opsize, reg3_scale} <= 10'($random(seed));
        {addressingmode, usereg2, usereg3, is_rep, mem1_rw, mem2_rw} <= 8'($random(seed));
        disp <= $random(seed);
        dest_gpr <= 8'($random(seed) & $random(seed) & $random(seed));
        dest_seg <= 8'($random(seed) & $random(seed) & $random(seed) & $random(seed));
        {wb_ld1, wb_ld2, wb_seg_ld} <= 3'($random(seed));
        wb_addr1 <= a;
        {wb_addr2, wb_seg_addr, wb_opsize} <= 8'($random(seed));
        wb_data1 <= $random(seed);
        wb_data2 <= $random(seed);
        wb_seg_data <= 16'($random(seed));
        wb_tag <= $random(seed) & 1 ? m_gtag[a] : 7'($random(seed)); // often the real owner.
    endtask

    initial begin
        for (int k = 0; k < `RRAG_NUM_REGS; k++) begin
            {m_gpr[k], m_gtag[k], m_gpend[k], m_seg[k], m_stag[k], m_spend[k]} = '0;
        end
        m_tag = '0;
        reset = 1'b1;
        drive_idle();
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        repeat (3000) begin
            drive_random();
            cycle("random");
        end
        drive_idle();
        ptc_clear <= 1'b1;
        cycle("flush");

        // dependency stall on a gpr base register.
        drive_idle();
        valid_in <= 1'b1;
        dest_gpr <= 8'h08;
        cycle("dep alloc");
        owner_tag = m_gtag[3];
        drive_idle();
        valid_in <= 1'b1;
        mem1_rw <= 2'd1;
        usereg2 <= 1'b1;
        reg_addr2 <= 3'd3;
        cycle("dep hold");
        check_bit("dep stall", 1'b1, last_stall);
        wb_ld1 <= 1'b1;
        wb_addr1 <= 3'd3;
        wb_data1 <= 32'hcafe_0042;
        wb_opsize <= 2'd2;
        wb_tag <= owner_tag + 7'd1;
        cycle("stale wb");
        wb_ld1 <= 1'b0;
        cycle("stale check");
        check_bit("stale pending", 1'b1, last_stall);
        wb_ld1 <= 1'b1;
        wb_tag <= owner_tag;
        cycle("owner wb");
        wb_ld1 <= 1'b0;
        wait_stall_low("dep release", 8);

        // pending clear without writeback.
        drive_idle();
        valid_in <= 1'b1;
        dest_gpr <= 8'h20;
        cycle("clear alloc");
        drive_idle();
        valid_in <= 1'b1;
        mem1_rw <= 2'd2;
        usereg3 <= 1'b1;
        reg_addr3 <= 3'd5;
        cycle("clear hold");
        check_bit("clear stall", 1'b1, last_stall);
        ptc_clear <= 1'b1;
        cycle("clear pulse");
        ptc_clear <= 1'b0;
        wait_stall_low("clear release", 8);

        // selector writeback, readback and segment dependency.
        drive_idle();
        wb_seg_ld <= 1'b1;
        wb_seg_addr <= 3'd4;
        wb_seg_data <= 16'h1234;
        cycle("seg wb");
        wb_seg_ld <= 1'b0;
        seg_addr1 <= 3'd4;
        cycle("seg read");
        drive_idle();
        valid_in <= 1'b1;
        dest_seg <= 8'h04;
        cycle("seg alloc");
        owner_tag = m_stag[2];
        drive_idle();
        valid_in <= 1'b1;
        mem2_rw <= 2'd3;
        seg_addr2 <= 3'd2;
        cycle("seg hold");
        check_bit("seg stall", 1'b1, last_stall);
        wb_seg_ld <= 1'b1;
        wb_seg_addr <= 3'd2;
        wb_seg_data <= 16'hbeef;
        wb_tag <= owner_tag;
        cycle("seg owner wb");
        wb_seg_ld <= 1'b0;
        wait_stall_low("seg release", 8);

        drive_idle();
        cycle("idle");
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* rrag.f */
+incdir+src
src/rrag_data_pkg.sv
src/rrag_uop_pkg.sv
src/rrag_ctrl.sv
src/gpr_file.sv
src/seg_file.sv
src/agu.sv
src/rrag_top.sv
verif/rrag_properties.sv
verif/rrag_tb.sv

/* Makefile */
SIM       := verilator
SIM_FLAGS := --binary --timing --assert -j 0
TOP       := rrag_tb
FILELIST  := rrag.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the rrag testbench with Verilator"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)
